/* counterBank.f */
rtl/counterPkg.sv
rtl/PrefixAnd.sv
rtl/IncDec.sv
rtl/CounterAlu.sv
rtl/CounterFile.sv
rtl/CounterPipe.sv
rtl/CounterBank.sv
testbench/tbCounterBank.sv

/* rtl/CounterAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module CounterAlu #(
	parameter int speed = 2  // prefix structure of the incrementer
) (
	input  wire counterPkg::cmdOpE       op,           // staged opcode
	input  wire [counterPkg::cntW-1:0]   data,         // load value
	input  wire [counterPkg::cntW-1:0]   curValue,     // counter before the op
	input  wire                          curWrapped,   // flag before the op
	output logic [counterPkg::cntW-1:0]  nextValue,    // counter after the op
	output logic                         nextWrapped,  // flag after the op
	output logic                         writeEn       // op changes state
);

	logic [counterPkg::cntW-1:0] stepValue;  // curValue +/- 1
	logic                        isInc;
	logic                        isDec;
	logic                        wrap;       // step crossed the all-ones/zero boundary

	assign isInc = (op == counterPkg::opInc);
	assign isDec = (op == counterPkg::opDec);

	IncDec #(
		.width(counterPkg::cntW),
		.speed(speed)
	) i_IncDec (
		.A(curValue),
		.DEC(isDec),
		.Z(stepValue)
	);

	// result side detection, no separate carry out needed
	assign wrap = (isInc && (stepValue == '0)) || (isDec && (stepValue == '1));

	always_comb begin
		nextValue   = curValue;    // read and unknown ops keep state
		nextWrapped = curWrapped;
		writeEn     = 1'b1;
		case (op)
			counterPkg::opInc,
			counterPkg::opDec: begin
				nextValue   = stepValue;
				nextWrapped = curWrapped | wrap;  // sticky
			end
			counterPkg::opLoad: nextValue = data;  // flag survives a load
			counterPkg::opClear: begin
				nextValue   = '0;
				nextWrapped = 1'b0;  // only way to drop the flag
			end
			default: writeEn = 1'b0;  // opRead
		endcase
	end

	// boundary steps seen from the operand side, so this also checks IncDec
	always_comb begin
		assert #0 (!(isInc && (&curValue)) || (nextWrapped && (nextValue == '0)))
			else $error("CounterAlu: increment from all ones did not wrap");
		assert #0 (!(isDec && (curValue == '0)) || (nextWrapped && (&nextValue)))
			else $error("CounterAlu: decrement from zero did not wrap");
	end

endmodule

`default_nettype wire

/* rtl/CounterBank.sv */
`timescale 1ns/10ps
`default_nettype none

module CounterBank #(
	parameter int speed = 2  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  wire                    clk,
	input  wire                    arstN,
	input  wire                    cmdValid,  // one command per cycle, no stall
	input  wire  counterPkg::cmdT  cmd,
	output logic                   rspValid,  // two cycles after cmdValid
	output counterPkg::rspT        rsp
);

	counterPkg::cmdOpE            stageOp;
	logic [counterPkg::cntW-1:0]  stageData;
	logic [counterPkg::chanW-1:0] stageChan;
	logic [counterPkg::cntW-1:0]  curValue;     // file read data
	logic                         curWrapped;
	logic [counterPkg::cntW-1:0]  nextValue;    // alu result
	logic                         nextWrapped;
	logic                         writeEn;      // op modifies state
	logic                         wrEn;         // qualified by stage valid

	CounterPipe i_CounterPipe (
		.clk(clk),
		.arstN(arstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.stageOp(stageOp),
		.stageData(stageData),
		.stageChan(stageChan),
		.writeEn(writeEn),
		.nextValue(nextValue),
		.nextWrapped(nextWrapped),
		.wrEn(wrEn),
		.rspValid(rspValid),
		.rsp(rsp)
	);

	// same channel for read and write, so read-modify-write is one cycle
	CounterFile i_CounterFile (
		.clk(clk),
		.arstN(arstN),
		.rdChan(stageChan),
		.curValue(curValue),
		.curWrapped(curWrapped),
		.wrEn(wrEn),
		.wrChan(stageChan),
		.wrValue(nextValue),
		.wrWrapped(nextWrapped)
	);

	CounterAlu #(
		.speed(speed)
	) i_CounterAlu (
		.op(stageOp),
		.data(stageData),
		.curValue(curValue),
		.curWrapped(curWrapped),
		.nextValue(nextValue),
		.nextWrapped(nextWrapped),
		.writeEn(writeEn)
	);

endmodule

`default_nettype wire

/* rtl/CounterFile.sv */
`timescale 1ns/10ps
`default_nettype none

module CounterFile (
	input  wire                           clk,
	input  wire                           arstN,
	// read port, combinational
	input  wire  [counterPkg::chanW-1:0]  rdChan,
	output logic [counterPkg::cntW-1:0]   curValue,
	output logic                          curWrapped,
	// write port, lands on the rising edge
	input  wire                           wrEn,
	input  wire  [counterPkg::chanW-1:0]  wrChan,
	input  wire  [counterPkg::cntW-1:0]   wrValue,
	input  wire                           wrWrapped
);

	logic [counterPkg::cntW-1:0]  cntQ [counterPkg::chanN];  // counter per channel
	logic [counterPkg::chanN-1:0] wrapQ;                     // sticky flag per channel

	// one counter and one sticky flag per channel
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int c = 0; c < counterPkg::chanN; c++) begin
				cntQ[c] <= '0;
			end
			wrapQ <= '0;
		end else if (wrEn) begin
			cntQ[wrChan]  <= wrValue;
			wrapQ[wrChan] <= wrWrapped;
		end
	end

	// read sees the old value in the write cycle
	assign curValue   = cntQ[rdChan];
	assign curWrapped = wrapQ[rdChan];

	// a set flag drops only together with a zeroed counter
	assert property (@(posedge clk) disable iff (!arstN)
		(wrEn && wrapQ[wrChan] && !wrWrapped) |-> (wrValue == '0))
		else $error("CounterFile: wrap flag of channel %0d dropped without a clear", wrChan);

endmodule

`default_nettype wire

/* rtl/CounterPipe.sv */
`timescale 1ns/10ps
`default_nettype none

module CounterPipe (
	input  wire                           clk,
	input  wire                           arstN,
	// host command
	input  wire                           cmdValid,
	input  wire  counterPkg::cmdT         cmd,
	// staged command to file and alu
	output counterPkg::cmdOpE             stageOp,
	output logic [counterPkg::cntW-1:0]   stageData,
	output logic [counterPkg::chanW-1:0]  stageChan,  // read and write address
	// alu result
	input  wire                           writeEn,
	input  wire  [counterPkg::cntW-1:0]   nextValue,
	input  wire                           nextWrapped,
	output logic                          wrEn,       // write strobe to the file
	// response to host
	output logic                          rspValid,
	output counterPkg::rspT               rsp
);

	counterPkg::cmdT stageQ;      // command being executed
	logic            stageValid;  // stageQ holds a live command

	// control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stageValid <= 1'b0;
			rspValid   <= 1'b0;
		end else begin
			stageValid <= cmdValid;
			rspValid   <= stageValid;
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (cmdValid) begin
			stageQ <= cmd;
		end
		if (stageValid) begin
			rsp.chan    <= stageQ.chan;
			rsp.value   <= nextValue;    // value after the op
			rsp.wrapped <= nextWrapped;
		end
	end

	assign stageOp   = stageQ.op;
	assign stageData = stageQ.data;
	assign stageChan = stageQ.chan;

	// idle stage must not touch the file
	assign wrEn = stageValid & writeEn;

	// response two cycles after the command and on its channel
	assert property (@(posedge clk) disable iff (!arstN)
		cmdValid |-> ##2 (rspValid && (rsp.chan == $past(cmd.chan, 2))))
		else $error("CounterPipe: response missing or on wrong channel");

endmodule

`default_nettype wire

/* rtl/IncDec.sv */
`timescale 1ns/10ps
`default_nettype none

// Z = A+1 or A-1, modulo 2^width
module IncDec #(
	parameter int width = 16,  // operand width
	parameter int speed = 2    // prefix structure, see PrefixAnd
) (
	input  wire  [width-1:0] A,    // operand
	input  wire              DEC,  // high for decrement
	output logic [width-1:0] Z     // result
);

	logic [width-1:0] prop;    // bits that pass a carry or borrow
	logic [width-1:0] prefix;  // all bits up to i propagate
	logic [width-1:0] flip;    // bits to toggle

	// increment ripples through ones, decrement through zeros
	assign prop = A ^ {width{DEC}};

	PrefixAnd #(
		.width(width),
		.speed(speed)
	) i_PrefixAnd (
		.PI(prop),
		.PO(prefix)
	);

	// lsb always toggles
	assign flip = {prefix[width-2:0], 1'b1};
	assign Z    = A ^ flip;

endmodule

`default_nettype wire

/* rtl/PrefixAnd.sv */
`timescale 1ns/10ps
`default_nettype none

module PrefixAnd #(
	parameter int width = 16,  // operand width
	parameter int speed = 2    // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  wire  [width-1:0] PI,  // propagate in
	output logic [width-1:0] PO   // prefix and, PO[i] = &PI[i:0]
);

	localparam int m = (width > 1) ? $clog2(width) : 0;  // levels per sweep

	if ((speed < 0) || (speed > 2)) begin : gBadSpeed
		$error("PrefixAnd: speed must be 0, 1 or 2");
	end

	if (speed == 0) begin : gSerial
		// ripple chain, depth width-1, fewest gates
		logic [width-1:0] chain;

		assign chain[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : gBit
			assign chain[i] = chain[i-1] & PI[i];
		end
		assign PO = chain;
	end else if (speed == 1) begin : gBrentKung
		// up-sweep then down-sweep, depth 2m-1, about 2*width gates
		localparam int depth = (m > 0) ? 2*m - 1 : 0;
		logic [depth:0][width-1:0] pt;  // one row per level

		assign pt[0] = PI;

		// up-sweep builds block ands at positions 2^l-1, 2*2^l-1, ...
		for (genvar l = 1; l <= m; l++) begin : gUp
			for (genvar i = 0; i < width; i++) begin : gBit
				if (((i + 1) % (2**l)) == 0) begin : gNode
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2**(l-1)];
				end else begin : gPass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		// down-sweep fills the mid points with full prefixes
		for (genvar d = 1; d < m; d++) begin : gDown
			localparam int lv = m - d;  // span halves each level
			for (genvar i = 0; i < width; i++) begin : gBit
				if ((((i + 1) % (2**lv)) == 2**(lv-1)) && (i >= 2**lv)) begin : gNode
					assign pt[m+d][i] = pt[m+d-1][i] & pt[m+d-1][i - 2**(lv-1)];
				end else begin : gPass
					assign pt[m+d][i] = pt[m+d-1][i];
				end
			end
		end

		assign PO = pt[depth];
	end else begin : gSklansky
		// divide and conquer, depth m, fanout doubles per level
		logic [m:0][width-1:0] pt;

		assign pt[0] = PI;
		for (genvar l = 1; l <= m; l++) begin : gLevel
			for (genvar i = 0; i < width; i++) begin : gBit
				// upper half of each 2^l block takes the last bit of the lower half
				if (((i >> (l-1)) % 2) == 1) begin : gNode
					assign pt[l][i] = pt[l-1][i] & pt[l-1][((i >> (l-1)) << (l-1)) - 1];
				end else begin : gPass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign PO = pt[m];
	end

endmodule

`default_nettype wire

/* rtl/counterPkg.sv */
`default_nettype none

package counterPkg;

	// counter geometry
	localparam int cntW  = 16;  // counter width
	localparam int chanN = 8;   // number of channels
	localparam int chanW = 3;   // channel index width, log2 of chanN

	// command opcodes
	typedef enum logic [2:0] {
		opRead  = 3'd0,  // return value, no write
		opInc   = 3'd1,  // count up by one
		opDec   = 3'd2,  // count down by one
		opLoad  = 3'd3,  // load data, keep wrap flag
		opClear = 3'd4   // zero value and wrap flag
	} cmdOpE;

	// command word from the host, 22 bits
	typedef struct packed {
		cmdOpE            op;    // what to do
		logic [chanW-1:0] chan;  // target channel
		logic [cntW-1:0]  data;  // load value, ignored otherwise
	} cmdT;

	// response word, 20 bits
	typedef struct packed {
		logic [chanW-1:0] chan;     // channel of the command
		logic [cntW-1:0]  value;    // counter after the op
		logic             wrapped;  // sticky wrap flag after the op
	} rspT;

endpackage

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# builds and runs the testbench once per prefix structure
cd "$(dirname "$0")" || exit 1
status=0
for speed in 0 1 2; do
	rm -rf "obj_dir_$speed"
	verilator --binary --timing --assert -Gspeed=$speed --top-module tbCounterBank \
		-f counterBank.f --Mdir "obj_dir_$speed" -o simv > "build_$speed.log" 2>&1 &&
	"./obj_dir_$speed/simv" > "sim_$speed.log" 2>&1 &&
	grep -qx "Simulation PASSED" "sim_$speed.log" &&
	echo "speed $speed passed" ||
	{ echo "speed $speed failed"; status=1; }
done
exit $status

/* testbench/counterBankGolden.txt */
# columns: op chan data expValue expWrap, all hex
# op: 0 read, 1 inc, 2 dec, 3 load, 4 clear
# reset state, every channel
0 0 0000 0000 0
0 1 0000 0000 0
0 2 0000 0000 0
0 3 0000 0000 0
0 4 0000 0000 0
0 5 0000 0000 0
0 6 0000 0000 0
0 7 0000 0000 0
# load then back to back steps on one channel
3 2 1234 1234 0
1 2 0000 1235 0
1 2 0000 1236 0
1 2 0000 1237 0
2 2 0000 1236 0
0 2 0000 1236 0
# increment wrap, flag sticky through steps and load, clear drops it
3 5 fffe fffe 0
1 5 0000 ffff 0
1 5 0000 0000 1
1 5 0000 0001 1
2 5 0000 0000 1
3 5 00ff 00ff 1
0 5 0000 00ff 1
4 5 0000 0000 0
0 5 0000 0000 0
# decrement wrap interleaved with another channel
3 3 8000 8000 0
2 6 0000 ffff 1
1 3 0000 8001 0
2 6 0000 fffe 1
2 3 0000 8000 0
2 3 0000 7fff 0
1 6 0000 ffff 1
1 6 0000 0000 1
0 3 0000 7fff 0
0 2 0000 1236 0
4 6 0000 0000 0
1 6 0000 0001 0
# data ignored unless load
1 7 abcd 0001 0
0 7 5555 0001 0
# long carry and borrow chains
3 4 00ff 00ff 0
1 4 0000 0100 0
2 4 0000 00ff 0
3 4 0f00 0f00 0
2 4 0000 0eff 0
1 3 0000 8000 0

/* testbench/tbCounterBank.sv */
`timescale 1ns/10ps
`default_nettype none

module tbCounterBank #(
	parameter int speed = 2  // prefix structure of the DUT incrementer
);

	localparam int maxLines   = 1000;  // guard against a runaway file
	localparam int drainLimit = 50;    // cycles allowed for the last responses

	// expected response and the cycle its command was driven
	typedef struct packed {
		counterPkg::rspT rsp;
		logic [31:0]     cycle;
	} expT;

	logic            clk;
	logic            arstN;
	logic            cmdValid;
	counterPkg::cmdT cmd;
	logic            rspValid;
	counterPkg::rspT rsp;

	logic [31:0] cycleCnt = '0;  // rising edges so far
	expT         expQ[$];        // one entry per command, issue order
	expT         expHead;        // entry being checked
	int          errorCnt;
	int          checkCnt;
	int          cmdCnt;

	CounterBank #(
		.speed(speed)
	) i_CounterBank (
		.clk(clk),
		.arstN(arstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.rspValid(rspValid),
		.rsp(rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCnt++;
		if (got !== exp) begin
			$display("error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			errorCnt++;
		end
	endtask

	// one command on the falling edge, expected response queued with it
	task automatic driveCommand(input int op, input int chan, input int data,
		input int expValue, input int expWrap);
		expT e;
		@(negedge clk);
		cmdValid      = 1'b1;
		cmd.op        = counterPkg::cmdOpE'(op[2:0]);
		cmd.chan      = chan[counterPkg::chanW-1:0];
		cmd.data      = data[counterPkg::cntW-1:0];
		e.rsp.chan    = chan[counterPkg::chanW-1:0];
		e.rsp.value   = expValue[counterPkg::cntW-1:0];
		e.rsp.wrapped = expWrap[0];
		e.cycle       = cycleCnt;  // sampled on the next rising edge
		expQ.push_back(e);
		cmdCnt++;
	endtask

	task automatic runGoldenFile();
		int    fd;
		int    lineNo;
		int    fields;
		int    op;
		int    chan;
		int    data;
		int    expValue;
		int    expWrap;
		string line;
		fd = $fopen("testbench/counterBankGolden.txt", "r");
		if (fd == 0) begin
			$display("cannot open the golden file testbench/counterBankGolden.txt");
			errorCnt++;
			return;
		end
		lineNo = 0;
		while (($fgets(line, fd) != 0) && (lineNo < maxLines)) begin
			lineNo++;
			if (line.getc(0) == "#") continue;  // column notes
			fields = $sscanf(line, "%h %h %h %h %h", op, chan, data, expValue, expWrap);
			if (fields <= 0) continue;  // blank line
			if ((fields != 5) || (op > 4) || (chan >= counterPkg::chanN)) begin
				$display("golden file line %0d is malformed", lineNo);
				errorCnt++;
			end else begin
				driveCommand(op, chan, data, expValue, expWrap);
			end
		end
		if (lineNo >= maxLines) begin
			$display("golden file is longer than %0d lines", maxLines);
			errorCnt++;
		end
		$fclose(fd);
		@(negedge clk);
		cmdValid = 1'b0;  // bus idle from here
	endtask

	task automatic waitForDrain();
		int waited;
		waited = 0;
		while ((expQ.size() != 0) && (waited < drainLimit)) begin
			@(negedge clk);
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("timeout: %0d responses never arrived", expQ.size());
			errorCnt++;
		end
	endtask

	// outputs settle after the rising edge, so look on the falling one
	always @(negedge clk) begin
		if (arstN && rspValid) begin
			if (expQ.size() == 0) begin
				$display("response on channel %0d arrived with no command outstanding",
					rsp.chan);
				errorCnt++;
			end else begin
				expHead = expQ.pop_front();
				checkValue("rsp.chan", 32'(rsp.chan), 32'(expHead.rsp.chan));
				checkValue("rsp.value", 32'(rsp.value), 32'(expHead.rsp.value));
				checkValue("rsp.wrapped", 32'(rsp.wrapped), 32'(expHead.rsp.wrapped));
				checkValue("rspLatency", cycleCnt - expHead.cycle, 32'd2);  // 2 edges
			end
		end
	end

	initial begin
		arstN    = 1'b0;
		cmdValid = 1'b0;
		cmd      = '0;
		errorCnt = 0;
		checkCnt = 0;
		cmdCnt   = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		runGoldenFile();
		waitForDrain();
		if (cmdCnt == 0) begin
			$display("no commands were read from the golden file");
			errorCnt++;
		end
		$display("commands %0d, checks %0d, errors %0d", cmdCnt, checkCnt, errorCnt);
		if (errorCnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
